/* common/redundant_rx_pkg.sv */
package redundant_rx_pkg;

	// ====================
	// sizes
	// ====================

	localparam int NUM_COPIES = 3;  // copies per set, smallest set that can vote
	localparam int BYTE_W     = 8;

	// ====================
	// types
	// ====================

	typedef logic [BYTE_W-1:0] byte_t;

	typedef logic [1:0] copy_id_t;  // 1..NUM_COPIES, 0 is none

	// bit 0 stands for copy 1
	typedef logic [NUM_COPIES-1:0] copy_mask_t;

	typedef enum logic [1:0] {
		cap_idle,     // waiting for rx_en
		cap_header,   // counting bytes up to the copy number
		cap_payload,  // streaming payload into the store
		cap_skip      // dropping the rest of the frame
	} cap_state_t;

	typedef enum logic [1:0] {
		vote_idle,
		vote_compare,  // byte sweep over all copies
		vote_decide,
		vote_replay    // chosen copy out on data_out
	} vote_state_t;

endpackage

/* verilog/frame_capture.sv */
`timescale 1ns/100ps

module frame_capture #(
	parameter int ID_OFFSET = 22,
	parameter int ADDR_W    = 6
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         rx_en,
	input  redundant_rx_pkg::byte_t      rx_data,
	input  logic                         busy,
	output logic                         wr_en,
	output redundant_rx_pkg::copy_id_t   wr_copy,
	output logic [ADDR_W-1:0]            wr_addr,
	output redundant_rx_pkg::byte_t      wr_data,
	output logic                         set_done,
	output redundant_rx_pkg::copy_mask_t copy_present,
	output logic [ADDR_W:0]              len1,
	output logic [ADDR_W:0]              len2,
	output logic [ADDR_W:0]              len3
);
	import redundant_rx_pkg::*;

	localparam int IDX_W = $clog2(ID_OFFSET + 1);

	cap_state_t       state;
	logic             rx_en_q;
	byte_t            rx_data_q;
	logic [IDX_W-1:0] idx;        // index of the byte in rx_data_q
	copy_id_t         cur_copy;
	logic [ADDR_W:0]  cnt;        // payload bytes taken so far
	logic [ADDR_W:0]  cnt_next;
	logic [ADDR_W:0]  len_q [NUM_COPIES];
	logic             at_id;
	logic             id_ok;
	logic             frame_end;
	copy_id_t         end_copy;
	logic [ADDR_W:0]  end_len;

	assign at_id    = (state == cap_header) && rx_en_q && (idx == IDX_W'(ID_OFFSET));
	assign id_ok    = (rx_data_q[1:0] != 2'd0);
	assign cnt_next = cnt[ADDR_W] ? cnt : cnt + 1'b1;  // saturates, rest is dropped

	// a frame ends when rx_en drops right after the id byte or a payload byte
	assign frame_end = !rx_en && ((at_id && id_ok) || (state == cap_payload));
	assign end_copy  = (state == cap_payload) ? cur_copy : copy_id_t'(rx_data_q[1:0]);
	assign end_len   = (state == cap_payload) ? cnt_next : '0;

	// ====================
	// control
	// ====================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= cap_idle;
			rx_en_q      <= 1'b0;
			wr_en        <= 1'b0;
			set_done     <= 1'b0;
			copy_present <= '0;
		end else begin
			rx_en_q  <= rx_en;
			wr_en    <= 1'b0;
			set_done <= 1'b0;
			if (set_done)
				copy_present <= '0;  // fresh mask for next set
			if (frame_end) begin
				copy_present[end_copy - 1'b1] <= 1'b1;
				set_done <= (end_copy == copy_id_t'(NUM_COPIES));
			end
			case (state)
				cap_idle: begin
					if (rx_en_q)
						state <= busy ? cap_skip : cap_header;
				end
				cap_header: begin
					if (!rx_en_q)
						state <= cap_idle;  // too short, no id
					else if (at_id && !id_ok)
						state <= cap_skip;
					else if (at_id)
						state <= rx_en ? cap_payload : cap_idle;
				end
				cap_payload: begin
					wr_en <= !cnt[ADDR_W];
					if (!rx_en)
						state <= cap_idle;
				end
				default: begin
					if (!rx_en_q)
						state <= cap_idle;
				end
			endcase
		end
	end

	// ====================
	// datapath
	// ====================

	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;
		wr_data   <= rx_data_q;
		wr_addr   <= cnt[ADDR_W-1:0];
		wr_copy   <= cur_copy;
		if (state == cap_idle)
			idx <= IDX_W'(1);  // byte 0 is in rx_data_q now
		else if (state == cap_header)
			idx <= idx + 1'b1;
		if (at_id) begin
			cur_copy <= copy_id_t'(rx_data_q[1:0]);
			cnt      <= '0;
		end else if (state == cap_payload) begin
			cnt <= cnt_next;
		end
		if (frame_end)
			len_q[end_copy - 1'b1] <= end_len;
	end

	assign len1 = len_q[0];
	assign len2 = len_q[1];
	assign len3 = len_q[2];

endmodule

/* verilog/copy_store.sv */
`timescale 1ns/100ps

module copy_store #(
	parameter int ADDR_W = 6
) (
	input  logic                       clk,
	input  logic                       wr_en,
	input  redundant_rx_pkg::copy_id_t wr_copy,
	input  logic [ADDR_W-1:0]          wr_addr,
	input  redundant_rx_pkg::byte_t    wr_data,
	input  logic [ADDR_W-1:0]          rd_addr,
	output redundant_rx_pkg::byte_t    rd_data1,
	output redundant_rx_pkg::byte_t    rd_data2,
	output redundant_rx_pkg::byte_t    rd_data3
);
	import redundant_rx_pkg::*;

	localparam int DEPTH = 2 ** ADDR_W;

	// one memory per copy, all read at the same address
	for (genvar c = 0; c < NUM_COPIES; c++) begin : g_copy
		byte_t mem [DEPTH];
		byte_t rd_q;
		logic  we;

		assign we = wr_en && (wr_copy == copy_id_t'(c + 1));  // copy numbers start at 1

		always_ff @(posedge clk) begin
			if (we)
				mem[wr_addr] <= wr_data;
			rd_q <= mem[rd_addr];  // one cycle read
		end
	end

	assign rd_data1 = g_copy[0].rd_q;
	assign rd_data2 = g_copy[1].rd_q;
	assign rd_data3 = g_copy[2].rd_q;

endmodule

/* vote/copy_voter.sv */
`timescale 1ns/100ps

module copy_voter #(
	parameter int ADDR_W = 6
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         set_done,
	input  redundant_rx_pkg::copy_mask_t copy_present,
	input  logic [ADDR_W:0]              len1,
	input  logic [ADDR_W:0]              len2,
	input  logic [ADDR_W:0]              len3,
	input  redundant_rx_pkg::byte_t      rd_data1,
	input  redundant_rx_pkg::byte_t      rd_data2,
	input  redundant_rx_pkg::byte_t      rd_data3,
	output logic [ADDR_W-1:0]            rd_addr,
	output logic                         busy,
	output redundant_rx_pkg::byte_t      data_out,
	output logic                         en_out,
	output logic                         lost
);
	import redundant_rx_pkg::*;

	vote_state_t     state;
	logic [ADDR_W:0] l1;
	logic [ADDR_W:0] l2;
	logic [ADDR_W:0] scan_len;   // longest present copy
	logic [ADDR_W:0] rep_len;
	logic [ADDR_W:0] addr;
	logic [ADDR_W:0] cmp_idx;    // byte now on rd_data*
	logic            cmp_valid;
	logic            agree12;
	logic            agree13;
	logic            agree23;
	copy_id_t        sel;
	copy_id_t        winner;
	logic [ADDR_W:0] win_len;
	logic [ADDR_W:0] m1;
	logic [ADDR_W:0] m2;
	logic [ADDR_W:0] m3;
	logic [ADDR_W:0] m12;
	logic [ADDR_W:0] longest;

	// missing copies do not stretch the sweep
	assign m1      = copy_present[0] ? len1 : '0;
	assign m2      = copy_present[1] ? len2 : '0;
	assign m3      = copy_present[2] ? len3 : '0;
	assign m12     = (m1 > m2) ? m1 : m2;
	assign longest = (m12 > m3) ? m12 : m3;

	assign rd_addr   = addr[ADDR_W-1:0];
	assign cmp_valid = (state == vote_compare) && (addr != '0);
	assign cmp_idx   = addr - 1'b1;

	// lowest copy that agrees with another one
	always_comb begin
		if (agree12 || agree13) begin
			winner  = copy_id_t'(1);
			win_len = l1;
		end else if (agree23) begin
			winner  = copy_id_t'(2);
			win_len = l2;
		end else begin
			winner  = '0;
			win_len = '0;
		end
	end

	// ====================
	// control
	// ====================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= vote_idle;
			en_out <= 1'b0;
			lost   <= 1'b0;
		end else begin
			en_out <= 1'b0;
			lost   <= 1'b0;
			case (state)
				vote_idle: begin
					if (set_done)
						state <= vote_compare;
				end
				vote_compare: begin
					if (addr == scan_len)
						state <= vote_decide;
				end
				vote_decide: begin
					// clean only when copy 1 matches both others
					lost <= !(agree12 && agree13);
					if (winner != '0 && win_len != '0)
						state <= vote_replay;
					else
						state <= vote_idle;
				end
				default: begin
					en_out <= 1'b1;  // byte for rd_addr shows up next cycle
					if (addr + 1'b1 == rep_len)
						state <= vote_idle;
				end
			endcase
		end
	end

	// ====================
	// datapath
	// ====================

	always_ff @(posedge clk) begin
		case (state)
			vote_idle: begin
				addr <= '0;
				if (set_done) begin
					l1       <= len1;
					l2       <= len2;
					scan_len <= longest;
					agree12  <= copy_present[0] && copy_present[1] && (len1 == len2);
					agree13  <= copy_present[0] && copy_present[2] && (len1 == len3);
					agree23  <= copy_present[1] && copy_present[2] && (len2 == len3);
				end
			end
			vote_compare: begin
				addr <= addr + 1'b1;
				if (cmp_valid) begin
					// equal lengths within a live pair so one bound does
					if (cmp_idx < l1 && rd_data1 != rd_data2)
						agree12 <= 1'b0;
					if (cmp_idx < l1 && rd_data1 != rd_data3)
						agree13 <= 1'b0;
					if (cmp_idx < l2 && rd_data2 != rd_data3)
						agree23 <= 1'b0;
				end
			end
			vote_decide: begin
				sel     <= winner;
				rep_len <= win_len;
				addr    <= '0;
			end
			default: begin
				addr <= addr + 1'b1;
			end
		endcase
	end

	// copy 3 never wins since a lower agreeing copy always exists
	assign data_out = (sel == copy_id_t'(2)) ? rd_data2 : rd_data1;

	assign busy = set_done || (state != vote_idle) || en_out;

endmodule

/* verilog/redundant_rx.sv */
`timescale 1ns/100ps

module redundant_rx #(
	parameter int ID_OFFSET = 22,
	parameter int ADDR_W    = 6
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    rx_en,
	input  redundant_rx_pkg::byte_t rx_data,
	output redundant_rx_pkg::byte_t data_out,
	output logic                    en_out,
	output logic                    lost
);
	import redundant_rx_pkg::*;

	logic              wr_en;    // capture -> store
	copy_id_t          wr_copy;
	logic [ADDR_W-1:0] wr_addr;
	byte_t             wr_data;

	logic              set_done; // capture -> voter
	copy_mask_t        copy_present;
	logic [ADDR_W:0]   len1;
	logic [ADDR_W:0]   len2;
	logic [ADDR_W:0]   len3;

	logic [ADDR_W-1:0] rd_addr;  // voter <-> store
	byte_t             rd_data1;
	byte_t             rd_data2;
	byte_t             rd_data3;
	logic              busy;     // holds off new sets

	frame_capture #(.ID_OFFSET(ID_OFFSET), .ADDR_W(ADDR_W)) frame_capture_i (
		.clk(clk), .rst_n(rst_n),
		.rx_en(rx_en), .rx_data(rx_data), .busy(busy),
		.wr_en(wr_en), .wr_copy(wr_copy), .wr_addr(wr_addr), .wr_data(wr_data),
		.set_done(set_done), .copy_present(copy_present),
		.len1(len1), .len2(len2), .len3(len3)
	);

	copy_store #(.ADDR_W(ADDR_W)) copy_store_i (
		.clk(clk),
		.wr_en(wr_en), .wr_copy(wr_copy), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3)
	);

	copy_voter #(.ADDR_W(ADDR_W)) copy_voter_i (
		.clk(clk), .rst_n(rst_n),
		.set_done(set_done), .copy_present(copy_present),
		.len1(len1), .len2(len2), .len3(len3),
		.rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3),
		.rd_addr(rd_addr), .busy(busy),
		.data_out(data_out), .en_out(en_out), .lost(lost)
	);

endmodule

/* tests/redundant_rx_vectors.svh */
`ifndef REDUNDANT_RX_VECTORS_SVH
`define REDUNDANT_RX_VECTORS_SVH

// one row per copy set, with the columns
// len present corrupt bad_idx shorten exp_copy exp_lost id0_first
// masks use bit 0 for copy 1 and exp_copy 0 means no replay

typedef struct packed {
	logic [6:0] len;        // payload bytes per copy
	copy_mask_t present;    // copies that get sent
	copy_mask_t corrupt;    // copies with one byte flipped
	logic [5:0] bad_idx;    // position of the flipped byte
	copy_mask_t shorten;    // copies sent one byte short
	copy_id_t   exp_copy;
	logic       exp_lost;
	logic       id0_first;  // copy 0 frame ahead of the set
} vec_t;

localparam int NUM_ROWS = 9;

localparam vec_t VECTORS [NUM_ROWS] = '{
	'{7'd12, 3'b111, 3'b000, 6'd0,  3'b000, 2'd1, 1'b0, 1'b0},  // all clean
	'{7'd16, 3'b111, 3'b001, 6'd5,  3'b000, 2'd2, 1'b1, 1'b0},  // copy 1 bad
	'{7'd10, 3'b101, 3'b000, 6'd0,  3'b000, 2'd1, 1'b1, 1'b0},  // copy 2 missing
	'{7'd14, 3'b111, 3'b000, 6'd0,  3'b100, 2'd1, 1'b1, 1'b0},  // copy 3 short
	'{7'd8,  3'b111, 3'b111, 6'd3,  3'b000, 2'd0, 1'b1, 1'b0},  // all differ
	'{7'd12, 3'b111, 3'b000, 6'd0,  3'b000, 2'd1, 1'b0, 1'b1},  // copy 0 frame first
	'{7'd9,  3'b011, 3'b000, 6'd0,  3'b000, 2'd1, 1'b1, 1'b0},  // closed by empty copy 3
	'{7'd20, 3'b110, 3'b000, 6'd0,  3'b000, 2'd2, 1'b1, 1'b0},  // copy 1 missing
	'{7'd64, 3'b111, 3'b010, 6'd63, 3'b000, 2'd1, 1'b1, 1'b0}   // full depth, last byte bad
};

`endif

/* tests/redundant_rx_tb.sv */
`timescale 1ns/100ps

module redundant_rx_tb;
	import redundant_rx_pkg::*;

	`include "redundant_rx_vectors.svh"

	localparam int ID_OFFSET     = 22;
	localparam int ADDR_W        = 6;
	localparam int MAX_LEN       = 2 ** ADDR_W;
	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 16;
	localparam int GAP_CYCLES    = 4;
	localparam int SETTLE_CYCLES = 6;  // lets busy fall before the next set
	localparam int ROW_CYCLES    = 3 * (ID_OFFSET + MAX_LEN + 8) + 3 * MAX_LEN;
	localparam int LIMIT_CYCLES  = RESET_CYCLES + NUM_ROWS * ROW_CYCLES;

	logic        clk;
	logic        rst_n;
	logic        rx_en;
	byte_t       rx_data;
	byte_t       data_out;
	logic        en_out;
	logic        lost;

	logic [31:0] lcg_state;
	byte_t       frame_q [$];              // bytes of the frame being sent
	byte_t       model_mem [NUM_COPIES][MAX_LEN];
	int          model_len [NUM_COPIES];
	byte_t       out_q [$];                // every en_out byte of the run
	int          lost_count;
	int          out_base;
	int          lost_base;
	int          cur_row;
	vec_t        v;

	redundant_rx #(.ID_OFFSET(ID_OFFSET), .ADDR_W(ADDR_W)) redundant_rx_i (
		.clk(clk), .rst_n(rst_n), .rx_en(rx_en), .rx_data(rx_data),
		.data_out(data_out), .en_out(en_out), .lost(lost)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ====================
	// helpers
	// ====================

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input int idx, input byte_t got, input byte_t exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch %s row %0d byte %0d: got 0x%02h expected 0x%02h",
				name, cur_row, idx, got, exp));
	endtask

	task automatic check_lost(input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch lost row %0d: got 0x%0h expected 0x%0h",
				cur_row, got, exp));
	endtask

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic rand_byte(output byte_t b);
		lcg_state = lcg_step(lcg_state);
		b = lcg_state[23:16];  // upper bits run longer
	endtask

	// same payload in every copy, then the row's damage on top
	task automatic build_set(input vec_t row);
		byte_t b;
		for (int i = 0; i < int'(row.len); i++) begin
			rand_byte(b);
			for (int c = 0; c < NUM_COPIES; c++)
				model_mem[c][i] = b;
		end
		for (int c = 0; c < NUM_COPIES; c++) begin
			model_len[c] = row.shorten[c] ? int'(row.len) - 1 : int'(row.len);
			if (row.corrupt[c])  // different flip per copy
				model_mem[c][row.bad_idx] = model_mem[c][row.bad_idx] ^ byte_t'(8'h01 << c);
		end
	endtask

	task automatic drive_frame();
		foreach (frame_q[i]) begin
			@(posedge clk);
			#2;
			rx_en   = 1'b1;
			rx_data = frame_q[i];
		end
		@(posedge clk);
		#2;
		rx_en   = 1'b0;
		rx_data = '0;
		repeat (GAP_CYCLES) @(posedge clk);
	endtask

	task automatic send_frame(input copy_id_t id, input int n);
		byte_t b;
		frame_q.delete();
		for (int i = 0; i < ID_OFFSET; i++) begin
			rand_byte(b);
			frame_q.push_back(b);
		end
		rand_byte(b);
		frame_q.push_back({b[7:2], id});  // copy number in the low bits
		for (int i = 0; i < n; i++) begin
			if (id == 2'd0)
				rand_byte(b);
			else
				b = model_mem[int'(id) - 1][i];
			frame_q.push_back(b);
		end
		drive_frame();
	endtask

	function automatic int expected_len(input vec_t row);
		if (row.exp_copy == 2'd0)
			return 0;
		return model_len[int'(row.exp_copy) - 1];
	endfunction

	// replay end or the lost pulse tells when the set is over
	task automatic wait_for_set(input vec_t row);
		int exp_len;
		exp_len = expected_len(row);
		if (exp_len != 0) begin
			while (out_q.size() - out_base < exp_len)
				@(posedge clk);
		end else begin
			while (lost_count == lost_base)
				@(posedge clk);
		end
		repeat (SETTLE_CYCLES) @(posedge clk);
	endtask

	task automatic verify_set(input vec_t row);
		int exp_len;
		int got_len;
		int c;
		exp_len = expected_len(row);
		got_len = out_q.size() - out_base;
		if (got_len != exp_len)
			report_failure($sformatf("Mismatch en_out count row %0d: got 0x%0h expected 0x%0h",
				cur_row, got_len, exp_len));
		c = int'(row.exp_copy) - 1;
		for (int i = 0; i < exp_len; i++)
			check_byte("data_out", i, out_q[out_base + i], model_mem[c][i]);
		check_lost(lost_count != lost_base, row.exp_lost);
		if (lost_count - lost_base > 1)
			report_failure($sformatf("lost stayed high for more than one cycle in row %0d", cur_row));
	endtask

	// ====================
	// monitor and watchdog
	// ====================

	always @(negedge clk) begin
		if (rst_n) begin
			if (en_out)
				out_q.push_back(data_out);
			if (lost)
				lost_count = lost_count + 1;
		end
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		report_failure("the run hung and hit the watchdog limit");
	end

	// ====================
	// main sequence
	// ====================

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		rx_en      = 1'b0;
		rx_data    = '0;
		lost_count = 0;
		lcg_state  = 32'h226b0ab7;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (GAP_CYCLES) @(posedge clk);

		for (int r = 0; r < NUM_ROWS; r++) begin
			cur_row   = r;
			v         = VECTORS[r];
			out_base  = out_q.size();
			lost_base = lost_count;
			build_set(v);
			if (v.id0_first)
				send_frame(2'd0, int'(v.len));  // dropped by the capture
			for (int c = 0; c < NUM_COPIES; c++) begin
				if (v.present[c])
					send_frame(copy_id_t'(c + 1), model_len[c]);
			end
			if (!v.present[NUM_COPIES-1]) begin
				model_len[NUM_COPIES-1] = 0;  // empty copy 3 only closes the set
				send_frame(copy_id_t'(NUM_COPIES), 0);
			end
			wait_for_set(v);
			verify_set(v);
			$display("row %0d done", r);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* redundant_rx.f */
+incdir+tests
common/redundant_rx_pkg.sv
verilog/frame_capture.sv
verilog/copy_store.sv
vote/copy_voter.sv
verilog/redundant_rx.sv
tests/redundant_rx_tb.sv

/* Makefile */
SIM        = verilator
TOP        = redundant_rx_tb
RTL_TOP    = redundant_rx
FILELIST   = redundant_rx.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
